//--- files.f
+incdir+source
source/intra_pkg.sv
source/recon_store.sv
source/neighbor_fetch.sv
source/intra_pred4x4.sv
source/block_recon.sv
source/intra_recon_top.sv
tests/tb_intra_recon.sv

//--- run_sim.sh
#!/bin/sh
# Builds the intra reconstruction testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -f files.f --top-module tb_intra_recon
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_intra_recon)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1

//--- tests/tb_intra_recon.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module tb_intra_recon;
    import intra_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_REQUESTS = 23;
    localparam int LATENCY      = 32;
    localparam int BLK_COLS     = `INTRA_FRAME_W / 4;
    localparam int BLK_ROWS     = `INTRA_FRAME_H / 4;
    localparam int PIX_MAX      = (1 << `INTRA_PIX_BITS) - 1;

    logic        clk;
    logic        rst;
    logic        start;
    blk_req_t    req;
    logic        busy;
    logic        done;
    pix_block_t  recon;

    integer      seed;
    int          value_errors;
    int          timing_errors;
    int          cycle_cnt;
    int          accept_cycle;
    logic        in_flight;
    logic        done_last;
    int          top_n [8];
    int          left_n [4];
    int          pred_ref [16];
    int          exp_pix [16];
    logic [`INTRA_PIX_BITS-1:0] frame_model [`INTRA_FRAME_H][`INTRA_FRAME_W];

    intra_recon_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .recon (recon)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ##############################
    // Reference model
    // ##############################

    // Neighbors as the frame holds them and 128 outside the picture
    task automatic load_neighbors(input int row, input int col);
        int y0;
        int x0;
        y0 = row * 4;
        x0 = col * 4;
        for (int k = 0; k < 8; k++) begin
            if (row == 0 || (k >= 4 && col == BLK_COLS - 1)) begin
                top_n[k] = `INTRA_NA_PIXEL;
            end else begin
                top_n[k] = int'(frame_model[y0 - 1][x0 + k]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            if (col == 0) begin
                left_n[k] = `INTRA_NA_PIXEL;
            end else begin
                left_n[k] = int'(frame_model[y0 + k][x0 - 1]);
            end
        end
    endtask

    task automatic predict_block(input pred_mode_t mode);
        int dc;
        int n;
        dc = 4;
        for (int k = 0; k < 4; k++) begin
            dc = dc + top_n[k] + left_n[k];
        end
        dc = dc >> 3;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                n = x + y;
                case (mode)
                    mode_vertical:   pred_ref[y * 4 + x] = top_n[x];
                    mode_horizontal: pred_ref[y * 4 + x] = left_n[y];
                    mode_dc:         pred_ref[y * 4 + x] = dc;
                    default: begin
                        if (n == 6) begin
                            pred_ref[y * 4 + x] = (top_n[6] + 3 * top_n[7] + 2) >> 2;
                        end else begin
                            pred_ref[y * 4 + x] =
                                (top_n[n] + 2 * top_n[n + 1] + top_n[n + 2] + 2) >> 2;
                        end
                    end
                endcase
            end
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    task automatic send_block(input int row, input int col, input pred_mode_t mode,
                              input int res_span);
        int res;
        int sum;
        load_neighbors(row, col);
        predict_block(mode);
        req.blk_row = 8'(row);
        req.blk_col = 8'(col);
        req.mode    = mode;
        for (int i = 0; i < 16; i++) begin
            res = $random(seed) % res_span;
            // Block (0,0) also gets both ends of the residual range
            if (row == 0 && col == 0 && i < 2) begin
                res = (i == 0) ? -256 : 255;
            end
            req.residual[i] = 9'(res);
            sum = pred_ref[i] + res;
            exp_pix[i] = (sum < 0) ? 0 : ((sum > PIX_MAX) ? PIX_MAX : sum);
        end
        for (int i = 0; i < 16; i++) begin
            frame_model[row * 4 + i / 4][col * 4 + i % 4] = (`INTRA_PIX_BITS)'(exp_pix[i]);
        end
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    // Start pulse that the DUT must drop because a block is in flight
    task automatic send_ignored(input int row, input int col, input pred_mode_t mode);
        req.blk_row = 8'(row);
        req.blk_col = 8'(col);
        req.mode    = mode;
        for (int i = 0; i < 16; i++) begin
            req.residual[i] = 9'($random(seed) % 100);
        end
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_done();
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < LATENCY + 8) begin
            @(posedge clk);
            seen = done;
            waited++;
        end
        if (!seen) begin
            timing_errors++;
            $display("Timeout at %0t: no done within %0d cycles of start", $time, waited);
        end
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // ##############################
    // Checks
    // ##############################

    always @(posedge clk) begin
        cycle_cnt++;
        if (rst) begin
            in_flight = 1'b0;
            done_last = 1'b0;
        end else begin
            if (in_flight) begin
                if (done) begin
                    assert (cycle_cnt - accept_cycle == LATENCY) else begin
                        timing_errors++;
                        $display("Error at %0t: done latency = %0d, expected %0d",
                                 $time, cycle_cnt - accept_cycle, LATENCY);
                    end
                    assert (!busy) else begin
                        timing_errors++;
                        $display("Error at %0t: busy = %0b, expected 0", $time, busy);
                    end
                    for (int i = 0; i < 16; i++) begin
                        assert (int'(recon.pix[i]) == exp_pix[i]) else begin
                            value_errors++;
                            $display("Error at %0t: recon.pix[%0d] = %0d, expected %0d",
                                     $time, i, recon.pix[i], exp_pix[i]);
                        end
                    end
                    in_flight = 1'b0;
                end else begin
                    assert (busy) else begin
                        timing_errors++;
                        $display("Error at %0t: busy = %0b, expected 1", $time, busy);
                    end
                end
            end else begin
                assert (!done) else begin
                    timing_errors++;
                    $display("Error at %0t: done = %0b, expected 0", $time, done);
                end
                assert (!busy) else begin
                    timing_errors++;
                    $display("Error at %0t: busy = %0b, expected 0", $time, busy);
                end
            end
            assert (!(done && done_last)) else begin
                timing_errors++;
                $display("Error at %0t: done stayed high for more than one cycle", $time);
            end
            done_last = done;
            if (start && !in_flight) begin
                in_flight    = 1'b1;
                accept_cycle = cycle_cnt;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_REQUESTS * 40) @(posedge clk);
        $display("Watchdog expired at %0t before the test sequence finished", $time);
        $display("Simulation failed");
        $finish;
    end

    // ##############################
    // Test sequence
    // ##############################

    initial begin
        seed          = 32'hb334;
        value_errors  = 0;
        timing_errors = 0;
        cycle_cnt     = 0;
        accept_cycle  = 0;
        in_flight     = 1'b0;
        done_last     = 1'b0;
        rst           = 1'b1;
        start         = 1'b0;
        req           = '0;
        for (int y = 0; y < `INTRA_FRAME_H; y++) begin
            for (int x = 0; x < `INTRA_FRAME_W; x++) begin
                frame_model[y][x] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        idle_cycles(4);

        // Whole frame in raster order with the mode cycle advancing by one per block row
        // Block (0,0) starts in DC and block (2,3) predicts from the 128 top-right pixels
        for (int r = 0; r < BLK_ROWS; r++) begin
            for (int c = 0; c < BLK_COLS; c++) begin
                send_block(r, c, pred_mode_t'((r + c + 2) % 4),
                           (r == 0 && c == 0) ? 256 : 64);
                wait_done();
                idle_cycles(1);
            end
        end

        // Interior blocks with full neighbor sets including the top-right pixels
        send_block(1, 1, mode_vertical, 48);
        wait_done();
        idle_cycles(1);
        send_block(2, 2, mode_horizontal, 48);
        wait_done();
        idle_cycles(1);
        send_block(2, 1, mode_diag_down_left, 48);
        wait_done();
        idle_cycles(1);
        send_block(1, 2, mode_diag_down_left, 48);
        wait_done();
        idle_cycles(1);

        // A second start in the middle of a block goes nowhere
        send_block(3, 3, mode_dc, 48);
        idle_cycles(8);
        send_ignored(3, 0, mode_vertical);
        wait_done();
        idle_cycles(16);

        // Reads the left column of block (3,0) that the ignored start must leave unchanged
        send_block(3, 1, mode_horizontal, 48);
        wait_done();
        idle_cycles(2);

        $display("Value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- source/intra_recon_top.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module intra_recon_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  intra_pkg::blk_req_t    req,
    output logic                   busy,
    output logic                   done,
    output intra_pkg::pix_block_t  recon
);
    import intra_pkg::*;

    blk_req_t                        req_q;
    logic                            busy_q;
    logic                            go;
    logic                            accept;
    logic                            rd_en;
    logic [`INTRA_ADDR_BITS-1:0]     rd_addr;
    logic [`INTRA_PIX_BITS-1:0]      rd_data;
    logic                            wr_en;
    logic [`INTRA_ADDR_BITS-1:0]     wr_addr;
    logic [`INTRA_PIX_BITS-1:0]      wr_data;
    neighbors_t                      nbr;
    logic                            nbr_valid;
    pix_block_t                      pred;
    logic                            pred_valid;

    // ##############################
    // Request capture and busy
    // ##############################

    // Busy drops together with done so a new start can land right away
    assign busy   = busy_q && !done;
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            go     <= 1'b0;
        end else begin
            go <= accept;
            if (done) begin
                busy_q <= 1'b0;
            end
            if (accept) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // ##############################
    // Pipeline
    // ##############################

    recon_store i_store (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    neighbor_fetch i_fetch (
        .clk       (clk),
        .rst       (rst),
        .go        (go),
        .blk_row   (req_q.blk_row),
        .blk_col   (req_q.blk_col),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .nbr       (nbr),
        .nbr_valid (nbr_valid)
    );

    intra_pred4x4 i_pred (
        .clk        (clk),
        .rst        (rst),
        .nbr        (nbr),
        .nbr_valid  (nbr_valid),
        .mode       (req_q.mode),
        .pred       (pred),
        .pred_valid (pred_valid)
    );

    block_recon i_recon (
        .clk        (clk),
        .rst        (rst),
        .pred       (pred),
        .pred_valid (pred_valid),
        .residual   (req_q.residual),
        .blk_row    (req_q.blk_row),
        .blk_col    (req_q.blk_col),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .recon      (recon),
        .done       (done)
    );

endmodule

//--- source/block_recon.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module block_recon (
    input  logic                             clk,
    input  logic                             rst,
    input  intra_pkg::pix_block_t            pred,
    input  logic                             pred_valid,
    input  logic [15:0][`INTRA_PIX_BITS:0]   residual,
    input  logic [7:0]                       blk_row,
    input  logic [7:0]                       blk_col,
    output logic                             wr_en,
    output logic [`INTRA_ADDR_BITS-1:0]      wr_addr,
    output logic [`INTRA_PIX_BITS-1:0]       wr_data,
    output intra_pkg::pix_block_t            recon,
    output logic                             done
);
    import intra_pkg::*;

    pix_block_t                        clip_c;
    pix_block_t                        blk_q;
    logic signed [`INTRA_PIX_BITS+2:0] sum_v;
    logic                              active_q;
    logic [3:0]                        cnt;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum_v = $signed({3'b000, pred.pix[i]})
                  + (`INTRA_PIX_BITS+3)'($signed(residual[i]));
            if (sum_v < 0) begin
                clip_c.pix[i] = '0;
            end else if (sum_v > $signed((`INTRA_PIX_BITS+3)'({`INTRA_PIX_BITS{1'b1}}))) begin
                clip_c.pix[i] = '1;
            end else begin
                clip_c.pix[i] = sum_v[`INTRA_PIX_BITS-1:0];
            end
        end
    end

    // One pixel per cycle in raster order with cnt[3:2] as the row
    assign wr_en   = active_q;
    assign wr_data = blk_q.pix[cnt];
    assign wr_addr = pix_addr(int'(blk_row) * 4 + int'(cnt[3:2]),
                              int'(blk_col) * 4 + int'(cnt[1:0]));

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt      <= 4'd0;
            done     <= 1'b0;
        end else begin
            done <= active_q && cnt == 4'd15;
            if (pred_valid) begin
                active_q <= 1'b1;
                cnt      <= 4'd0;
            end else if (active_q) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'd15) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pred_valid) begin
            blk_q <= clip_c;
        end
        if (active_q && cnt == 4'd15) begin
            recon <= blk_q;
        end
    end

endmodule

//--- source/intra_pred4x4.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module intra_pred4x4 (
    input  logic                   clk,
    input  logic                   rst,
    input  intra_pkg::neighbors_t  nbr,
    input  logic                   nbr_valid,
    input  intra_pkg::pred_mode_t  mode,
    output intra_pkg::pix_block_t  pred,
    output logic                   pred_valid
);
    import intra_pkg::*;

    pix_block_t                    pred_c;
    logic [`INTRA_PIX_BITS+2:0]    dc_sum;
    logic [`INTRA_PIX_BITS+1:0]    ddl_sum;
    int                            n;

    // ##############################
    // Prediction
    // ##############################

    always_comb begin
        dc_sum = (`INTRA_PIX_BITS+3)'(4);
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + (`INTRA_PIX_BITS+3)'(nbr.top[k])
                            + (`INTRA_PIX_BITS+3)'(nbr.left[k]);
        end

        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                n = x + y;
                // The bottom-right sample repeats top 7 instead of reading past it
                if (n == 6) begin
                    ddl_sum = (`INTRA_PIX_BITS+2)'(nbr.top[6])
                            + (`INTRA_PIX_BITS+2)'(nbr.top[7]) * (`INTRA_PIX_BITS+2)'(3)
                            + (`INTRA_PIX_BITS+2)'(2);
                end else begin
                    ddl_sum = (`INTRA_PIX_BITS+2)'(nbr.top[n])
                            + ((`INTRA_PIX_BITS+2)'(nbr.top[n + 1]) << 1)
                            + (`INTRA_PIX_BITS+2)'(nbr.top[n + 2])
                            + (`INTRA_PIX_BITS+2)'(2);
                end

                case (mode)
                    mode_vertical:       pred_c.pix[y * 4 + x] = nbr.top[x];
                    mode_horizontal:     pred_c.pix[y * 4 + x] = nbr.left[y];
                    mode_dc:             pred_c.pix[y * 4 + x] = dc_sum[`INTRA_PIX_BITS+2:3];
                    mode_diag_down_left: pred_c.pix[y * 4 + x] = ddl_sum[`INTRA_PIX_BITS+1:2];
                endcase
            end
        end
    end

    // ##############################
    // Output register
    // ##############################

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= nbr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (nbr_valid) begin
            pred <= pred_c;
        end
    end

endmodule

//--- source/neighbor_fetch.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module neighbor_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         go,
    input  logic [7:0]                   blk_row,
    input  logic [7:0]                   blk_col,
    output logic                         rd_en,
    output logic [`INTRA_ADDR_BITS-1:0]  rd_addr,
    input  logic [`INTRA_PIX_BITS-1:0]   rd_data,
    output intra_pkg::neighbors_t        nbr,
    output logic                         nbr_valid
);
    import intra_pkg::*;

    fetch_state_t                       state;
    logic [3:0]                         idx_q;
    logic [3:0]                         cur_idx;
    logic                               issue;
    logic                               avail;
    logic                               row_first;
    logic                               col_first;
    logic                               col_last;
    logic                               cap_valid;
    logic                               cap_avail;
    logic [3:0]                         cap_idx;
    logic [`INTRA_PIX_BITS-1:0]         cap_pix;
    logic [12:0][`INTRA_PIX_BITS-1:0]   pix_q;
    logic [12:0][`INTRA_PIX_BITS-1:0]   pix_c;

    assign row_first = blk_row == 8'd0;
    assign col_first = blk_col == 8'd0;
    assign col_last  = blk_col == 8'(`INTRA_FRAME_W / 4 - 1);

    // Slot order is corner, top 0..7, left 0..3; the first read goes out with go
    assign issue   = (state != fetch_idle) || go;
    assign cur_idx = (state == fetch_idle) ? 4'd0 : idx_q;
    assign rd_en   = issue && avail;

    always_comb begin
        if (cur_idx == 4'd0) begin
            avail   = !row_first && !col_first;
            rd_addr = pix_addr(int'(blk_row) * 4 - 1, int'(blk_col) * 4 - 1);
        end else if (cur_idx <= 4'd8) begin
            // Top-right pixels are slots 5..8 and fall off the right edge
            avail   = !row_first && !(col_last && cur_idx >= 4'd5);
            rd_addr = pix_addr(int'(blk_row) * 4 - 1, int'(blk_col) * 4 + int'(cur_idx) - 1);
        end else begin
            avail   = !col_first;
            rd_addr = pix_addr(int'(blk_row) * 4 + int'(cur_idx) - 9, int'(blk_col) * 4 - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_idle;
            idx_q     <= 4'd0;
            cap_valid <= 1'b0;
            nbr_valid <= 1'b0;
        end else begin
            cap_valid <= issue;
            nbr_valid <= state == fetch_last;
            case (state)
                fetch_idle: begin
                    if (go) begin
                        state <= fetch_read;
                        idx_q <= 4'd1;
                    end
                end
                fetch_read: begin
                    idx_q <= idx_q + 4'd1;
                    if (idx_q == 4'd11) begin
                        state <= fetch_last;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    // Store data comes back one cycle after the read
    assign cap_pix = cap_avail ? rd_data : (`INTRA_PIX_BITS)'(`INTRA_NA_PIXEL);

    always_ff @(posedge clk) begin
        cap_idx   <= cur_idx;
        cap_avail <= avail;
        if (cap_valid) begin
            pix_q[cap_idx] <= cap_pix;
        end
    end

    // Last slot is passed straight through in the nbr_valid cycle
    always_comb begin
        pix_c = pix_q;
        if (cap_valid) begin
            pix_c[cap_idx] = cap_pix;
        end
        nbr.corner = pix_c[0];
        for (int k = 0; k < 8; k++) begin
            nbr.top[k] = pix_c[k + 1];
        end
        for (int k = 0; k < 4; k++) begin
            nbr.left[k] = pix_c[k + 9];
        end
    end

endmodule

//--- source/recon_store.sv
`timescale 1ns/10ps
`include "intra_cfg.svh"

module recon_store (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rd_en,
    input  logic [`INTRA_ADDR_BITS-1:0]  rd_addr,
    output logic [`INTRA_PIX_BITS-1:0]   rd_data,
    input  logic                         wr_en,
    input  logic [`INTRA_ADDR_BITS-1:0]  wr_addr,
    input  logic [`INTRA_PIX_BITS-1:0]   wr_data
);

    logic [`INTRA_PIX_BITS-1:0] frame [`INTRA_FRAME_W * `INTRA_FRAME_H];

    // ##############################
    // Power-up contents
    // ##############################

    // The frame starts black, so the first blocks see zeros wherever
    // a neighbor is inside the picture but not yet reconstructed
    initial begin
        for (int i = 0; i < `INTRA_FRAME_W * `INTRA_FRAME_H; i++) begin
            frame[i] = '0;
        end
    end

    // ##############################
    // Ports
    // ##############################

    always_ff @(posedge clk) begin
        if (wr_en) begin
            frame[wr_addr] <= wr_data;
        end
    end

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= frame[rd_addr];
        end
    end

endmodule

//--- source/intra_pkg.sv
`include "intra_cfg.svh"

package intra_pkg;

    typedef enum logic [1:0] {
        mode_vertical,
        mode_horizontal,
        mode_dc,
        mode_diag_down_left
    } pred_mode_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_read,
        fetch_last
    } fetch_state_t;

    // Residual samples are two's complement, raster order, index 0 top left
    typedef struct packed {
        logic [7:0]                          blk_row;
        logic [7:0]                          blk_col;
        pred_mode_t                          mode;
        logic [15:0][`INTRA_PIX_BITS:0]      residual;
    } blk_req_t;

    typedef struct packed {
        logic [7:0][`INTRA_PIX_BITS-1:0]     top;
        logic [3:0][`INTRA_PIX_BITS-1:0]     left;
        logic [`INTRA_PIX_BITS-1:0]          corner;
    } neighbors_t;

    typedef struct packed {
        logic [15:0][`INTRA_PIX_BITS-1:0]    pix;
    } pix_block_t;

    // Raster address of pixel (y, x) in the frame store
    function automatic logic [`INTRA_ADDR_BITS-1:0] pix_addr(input int y, input int x);
        return (`INTRA_ADDR_BITS)'(y * `INTRA_FRAME_W + x);
    endfunction

endpackage

//--- source/intra_cfg.svh
`ifndef INTRA_CFG_SVH
`define INTRA_CFG_SVH

// Frame geometry in pixels
// The width must be a multiple of the 4x4 block size
`define INTRA_FRAME_W 16
`define INTRA_FRAME_H 16

// Luma sample width
`define INTRA_PIX_BITS 8

// Substitute for a neighbor that lies outside the picture
`define INTRA_NA_PIXEL 128

// Address width of the reconstructed-frame store
`define INTRA_ADDR_BITS $clog2(`INTRA_FRAME_W * `INTRA_FRAME_H)

`endif
